// File: src/gnn_cfg_pkg.sv
package gnn_cfg_pkg;

    // command word width
    localparam int PKT_W = 16;

    localparam int NUM_PE   = 4;
    localparam int NUM_BANK = 4;

    // replay passes per job
    localparam int MAX_REPLAY = 4;
    localparam int ITER_W     = $clog2(MAX_REPLAY);

    // queue depths are powers of two
    localparam int CMD_DEPTH  = 8;
    localparam int TASK_DEPTH = 8;

    // back-end timing
    localparam int GRANT_DELAY      = 2;
    localparam int BANK_BUSY_CYCLES = 4;
    localparam int MAX_TASK_CYCLES  = 16;

    localparam int GNT_CNT_W  = $clog2(GRANT_DELAY + 1);
    localparam int BANK_CNT_W = $clog2(BANK_BUSY_CYCLES + 1);
    localparam int LANE_CNT_W = $clog2(MAX_TASK_CYCLES + 1);

endpackage

// File: src/gnn_pkt_pkg.sv
package gnn_pkt_pkg;
    import gnn_cfg_pkg::*;

    // top two bits of every command
    typedef enum logic [1:0] {
        op_task   = 2'b00,
        op_replay = 2'b01,
        op_stream = 2'b10,
        op_weight = 2'b11
    } cmd_op_t;

    // field positions in the command word
    localparam int MASK_HI    = 13;
    localparam int MASK_LO    = 10;
    localparam int PAYLOAD_HI = 13;
    localparam int PAYLOAD_LO = 0;
    localparam int FV_HI      = 4;
    localparam int FV_LO      = 0;
    localparam int WB_HI      = 3;
    localparam int WB_LO      = 0;
    localparam int BANK_HI    = 1;
    localparam int BANK_LO    = 0;
    localparam int DUR_HI     = 3;
    localparam int DUR_LO     = 0;

    localparam int MASK_W     = MASK_HI - MASK_LO + 1;
    localparam int TASK_W     = PAYLOAD_HI - PAYLOAD_LO + 1;
    localparam int FV_W       = FV_HI - FV_LO + 1;
    localparam int WB_W       = WB_HI - WB_LO + 1;
    localparam int BANK_IDX_W = BANK_HI - BANK_LO + 1;

    typedef logic [TASK_W-1:0] task_payload_t;

    typedef struct packed {
        cmd_op_t              op;
        logic [PKT_W-3:0]     body;
    } cmd_pkt_t;

    typedef struct packed {
        logic          valid;
        task_payload_t payload;
    } task_pkt_t;

    typedef struct packed {
        logic     valid;
        cmd_pkt_t packet;
    } mem_pkt_t;

endpackage

// File: src/dp_status_if.sv
`timescale 1ns/10ps

interface dp_status_if
    import gnn_cfg_pkg::*;
();
    logic [NUM_BANK-1:0] bank_busy;
    logic [NUM_PE-1:0]   pe_idle;
    logic                rs_empty;
    logic                stream_done;
    logic                vertex_done;
    logic                outbuff_available;

    modport backend (
        output bank_busy,
        output pe_idle,
        output rs_empty,
        output stream_done
    );

    // straight from the chip pins
    modport top_side (
        output vertex_done,
        output outbuff_available
    );

    modport decoder (
        input bank_busy,
        input pe_idle,
        input rs_empty,
        input stream_done,
        input vertex_done,
        input outbuff_available
    );

endinterface

// File: src/pkt_queue.sv
`timescale 1ns/10ps

module pkt_queue #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     pop_valid,
    output logic     full,
    output logic     empty
);

    payload_t                 mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_push;
    logic                     do_pop;

    assign full    = (count == ($clog2(DEPTH) + 1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            pop_valid <= do_pop;
        end
    end

    // storage and output word held while not popping
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

endmodule

// File: src/dispatch_decoder.sv
`timescale 1ns/10ps

module dispatch_decoder
    import gnn_cfg_pkg::*;
    import gnn_pkt_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  cmd_pkt_t          cmd,
    input  logic              cmd_valid,
    dp_status_if.decoder      status,
    input  logic              grant,
    output logic              req,
    output logic              fifo_stall,
    output task_pkt_t         task_out,
    output mem_pkt_t          mem_out,
    output logic              stream_begin,
    output logic              cntl_done,
    output logic              task_complete,
    output logic [ITER_W-1:0] replay_iter,
    output logic [FV_W-1:0]   num_fv,
    output logic [WB_W-1:0]   weights_boundary
);

    typedef enum logic [2:0] {
        idle,
        wait_grant,
        wait_replay,
        wait_stream,
        wait_task_complete
    } state_t;

    state_t            state;
    state_t            state_nx;
    cmd_pkt_t          pkt_q;
    cmd_pkt_t          pkt_nx;
    logic [ITER_W-1:0] iter_nx;
    logic [FV_W-1:0]   fv_nx;
    logic [WB_W-1:0]   wb_nx;
    logic              begin_nx;
    logic              replay_flag;
    logic              replay_flag_nx;
    logic [MASK_W-1:0] iter_mask;
    logic              backend_quiet;
    logic              decode_en;

    assign iter_mask     = cmd[MASK_HI:MASK_LO];
    assign backend_quiet = !(|status.bank_busy) && status.rs_empty && (&status.pe_idle);
    assign decode_en     = cmd_valid && (state == idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= idle;
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
            stream_begin     <= 1'b0;
            replay_flag      <= 1'b0;
        end else begin
            state            <= state_nx;
            replay_iter      <= iter_nx;
            num_fv           <= fv_nx;
            weights_boundary <= wb_nx;
            stream_begin     <= begin_nx;
            replay_flag      <= replay_flag_nx;
        end
    end

    // held command for grant and replay
    always_ff @(posedge clk) begin
        pkt_q <= pkt_nx;
    end

    always_comb begin
        state_nx       = state;
        pkt_nx         = pkt_q;
        iter_nx        = replay_iter;
        fv_nx          = num_fv;
        wb_nx          = weights_boundary;
        begin_nx       = 1'b0;
        replay_flag_nx = 1'b0;
        req            = 1'b0;
        fifo_stall     = 1'b0;
        task_out       = '0;
        mem_out        = '0;
        cntl_done      = 1'b0;
        task_complete  = 1'b0;

        case (state)
            idle: begin
                if (decode_en) begin
                    case (cmd.op)
                        op_task: begin
                            if (iter_mask[replay_iter]) begin
                                task_out.valid   = 1'b1;
                                task_out.payload = cmd[PAYLOAD_HI:PAYLOAD_LO];
                            end else begin
                                // not this pass so it goes out to memory
                                req        = 1'b1;
                                fifo_stall = 1'b1;
                                pkt_nx     = cmd;
                                state_nx   = wait_grant;
                            end
                        end
                        op_replay: begin
                            fifo_stall = 1'b1;
                            pkt_nx     = cmd;
                            state_nx   = wait_replay;
                        end
                        op_stream: begin
                            fv_nx    = cmd[FV_HI:FV_LO];
                            begin_nx = 1'b1;
                        end
                        op_weight: begin
                            wb_nx      = cmd[WB_HI:WB_LO];
                            fifo_stall = 1'b1;
                            state_nx   = wait_stream;
                        end
                        default: begin
                            state_nx = idle;
                        end
                    endcase
                end
            end
            wait_grant: begin
                req = 1'b1;
                if (grant) begin
                    mem_out.valid  = 1'b1;
                    mem_out.packet = pkt_q;
                    state_nx       = idle;
                end else begin
                    fifo_stall = 1'b1;
                end
            end
            wait_replay: begin
                fifo_stall = 1'b1;
                if (backend_quiet) begin
                    if (replay_iter == ITER_W'(MAX_REPLAY - 1)) begin
                        cntl_done = 1'b1;
                        state_nx  = wait_task_complete;
                    end else begin
                        // replay word restarts the stream for the next pass
                        mem_out.valid  = 1'b1;
                        mem_out.packet = pkt_q;
                        iter_nx        = replay_iter + 1'b1;
                        replay_flag_nx = 1'b1;
                        state_nx       = wait_stream;
                    end
                end
            end
            wait_stream: begin
                if (status.stream_done && !replay_flag) begin
                    state_nx = idle;
                end else begin
                    fifo_stall = 1'b1;
                end
            end
            wait_task_complete: begin
                // job finished and only reset gets out
                fifo_stall    = 1'b1;
                task_complete = status.vertex_done && status.outbuff_available;
            end
            default: begin
                state_nx = idle;
            end
        endcase
    end

endmodule

// File: src/exec_backend.sv
`timescale 1ns/10ps

module exec_backend
    import gnn_cfg_pkg::*;
    import gnn_pkt_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  task_pkt_t       task_in,
    input  mem_pkt_t        mem_in,
    input  logic            stream_begin,
    input  logic [FV_W-1:0] num_fv,
    input  logic            req,
    output logic            grant,
    dp_status_if.backend    status,
    output task_pkt_t       pe_issue
);

    task_payload_t           rs_data;
    logic                    rs_valid;
    logic                    rs_queue_empty;
    logic                    rs_pop;
    logic [LANE_CNT_W-1:0]   lane_cnt [NUM_PE];
    logic [NUM_PE-1:0]       lane_idle;
    logic [NUM_PE-1:0]       lane_load;
    logic [BANK_CNT_W-1:0]   bank_cnt [NUM_BANK];
    logic [NUM_BANK-1:0]     bank_busy;
    logic [BANK_IDX_W-1:0]   bank_sel;
    logic [GNT_CNT_W-1:0]    gnt_cnt;
    logic [FV_W-1:0]         fv_cnt;
    logic                    stream_start;

    pkt_queue #(
        .payload_t (task_payload_t),
        .DEPTH     (TASK_DEPTH)
    ) i_task_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (task_in.valid),
        .push_data (task_in.payload),
        .pop       (rs_pop),
        .pop_data  (rs_data),
        .pop_valid (rs_valid),
        .full      (),
        .empty     (rs_queue_empty)
    );

    // need a second idle lane when one task is already in flight
    assign rs_pop = !rs_queue_empty &&
                    (rs_valid ? ((lane_idle & (lane_idle - 1'b1)) != '0) : (|lane_idle));

    // lowest idle lane takes the head
    assign lane_load = rs_valid ? (lane_idle & (~lane_idle + 1'b1)) : '0;

    assign pe_issue.valid   = rs_valid;
    assign pe_issue.payload = rs_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PE; i++) begin
                lane_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PE; i++) begin
                if (lane_load[i]) begin
                    lane_cnt[i] <= LANE_CNT_W'(rs_data[DUR_HI:DUR_LO]) + 1'b1;
                end else if (lane_cnt[i] != '0) begin
                    lane_cnt[i] <= lane_cnt[i] - 1'b1;
                end
            end
        end
    end

    assign bank_sel = mem_in.packet[BANK_HI:BANK_LO];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BANK; i++) begin
                bank_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BANK; i++) begin
                if (mem_in.valid && bank_sel == BANK_IDX_W'(i)) begin
                    bank_cnt[i] <= BANK_CNT_W'(BANK_BUSY_CYCLES);
                end else if (bank_cnt[i] != '0) begin
                    bank_cnt[i] <= bank_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            lane_idle[i] = (lane_cnt[i] == '0);
        end
        for (int i = 0; i < NUM_BANK; i++) begin
            bank_busy[i] = (bank_cnt[i] != '0);
        end
    end

    // grant pulse a fixed delay after req rises
    assign grant = (gnt_cnt == GNT_CNT_W'(GRANT_DELAY));

    assign stream_start = stream_begin || (mem_in.valid && mem_in.packet.op == op_replay);

    always_ff @(posedge clk) begin
        if (reset) begin
            gnt_cnt <= '0;
            fv_cnt  <= '0;
        end else begin
            if (grant) begin
                gnt_cnt <= '0;
            end else if (req) begin
                gnt_cnt <= gnt_cnt + 1'b1;
            end
            if (stream_start) begin
                fv_cnt <= num_fv;
            end else if (fv_cnt != '0) begin
                fv_cnt <= fv_cnt - 1'b1;
            end
        end
    end

    assign status.bank_busy   = bank_busy;
    assign status.pe_idle     = lane_idle;
    // the popped word still counts as queued
    assign status.rs_empty    = rs_queue_empty && !rs_valid;
    assign status.stream_done = (fv_cnt == '0);

endmodule

// File: src/gnn_dispatch_top.sv
`timescale 1ns/10ps

module gnn_dispatch_top
    import gnn_cfg_pkg::*;
    import gnn_pkt_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_push,
    input  logic [PKT_W-1:0]  cmd_word,
    input  logic              vertex_done,
    input  logic              outbuff_available,
    output logic              cmd_full,
    output logic              pe_issue_valid,
    output logic [TASK_W-1:0] pe_issue_data,
    output logic              mem_valid,
    output logic [PKT_W-1:0]  mem_data,
    output logic              stream_begin,
    output logic              cntl_done,
    output logic              task_complete,
    output logic [ITER_W-1:0] replay_iter,
    output logic [FV_W-1:0]   num_fv,
    output logic [WB_W-1:0]   weights_boundary
);

    cmd_pkt_t  cmd_head;
    logic      cmd_valid;
    logic      fifo_stall;
    logic      req;
    logic      grant;
    task_pkt_t task_pkt;
    task_pkt_t pe_issue;
    mem_pkt_t  mem_pkt;

    dp_status_if status_if ();

    assign status_if.vertex_done       = vertex_done;
    assign status_if.outbuff_available = outbuff_available;

    assign pe_issue_valid = pe_issue.valid;
    assign pe_issue_data  = pe_issue.payload;
    assign mem_valid      = mem_pkt.valid;
    assign mem_data       = mem_pkt.packet;

    pkt_queue #(
        .payload_t (cmd_pkt_t),
        .DEPTH     (CMD_DEPTH)
    ) i_cmd_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (cmd_push),
        .push_data (cmd_pkt_t'(cmd_word)),
        .pop       (!fifo_stall),
        .pop_data  (cmd_head),
        .pop_valid (cmd_valid),
        .full      (cmd_full),
        .empty     ()
    );

    dispatch_decoder i_decoder (
        .clk              (clk),
        .reset            (reset),
        .cmd              (cmd_head),
        .cmd_valid        (cmd_valid),
        .status           (status_if.decoder),
        .grant            (grant),
        .req              (req),
        .fifo_stall       (fifo_stall),
        .task_out         (task_pkt),
        .mem_out          (mem_pkt),
        .stream_begin     (stream_begin),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary)
    );

    exec_backend i_backend (
        .clk          (clk),
        .reset        (reset),
        .task_in      (task_pkt),
        .mem_in       (mem_pkt),
        .stream_begin (stream_begin),
        .num_fv       (num_fv),
        .req          (req),
        .grant        (grant),
        .status       (status_if.backend),
        .pe_issue     (pe_issue)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// File: sim/gnn_dispatch_assert.sv
`timescale 1ns/10ps

module gnn_dispatch_assert (
    input logic clk,
    input logic reset,
    input logic req,
    input logic grant,
    input logic cntl_done,
    input logic in_wait_replay,
    input logic task_complete,
    input logic vertex_done,
    input logic outbuff_available
);

    // memory request held until the back end answers
    property req_held;
        @(posedge clk) disable iff (reset)
        req && !grant |=> req;
    endproperty

    property done_from_replay;
        @(posedge clk) disable iff (reset)
        cntl_done |-> in_wait_replay;
    endproperty

    property complete_needs_both;
        @(posedge clk) disable iff (reset)
        task_complete |-> (vertex_done && outbuff_available);
    endproperty

    assert property (req_held)
        else $error("req dropped before grant");

    assert property (done_from_replay)
        else $error("cntl_done raised outside the replay wait state");

    assert property (complete_needs_both)
        else $error("task_complete raised without vertex_done and outbuff_available");

endmodule

bind dispatch_decoder gnn_dispatch_assert i_assert (
    .clk               (clk),
    .reset             (reset),
    .req               (req),
    .grant             (grant),
    .cntl_done         (cntl_done),
    .in_wait_replay    (state == wait_replay),
    .task_complete     (task_complete),
    .vertex_done       (status.vertex_done),
    .outbuff_available (status.outbuff_available)
);

// File: sim/gnn_dispatch_tb.sv
`timescale 1ns/10ps

module gnn_dispatch_tb
    import gnn_cfg_pkg::*;
    import gnn_pkt_pkg::*;
();

    localparam int TIMEOUT   = 500;
    localparam int MAX_LINES = 128;

    logic              clk;
    logic              reset;
    logic              cmd_push;
    logic [PKT_W-1:0]  cmd_word;
    logic              vertex_done;
    logic              outbuff_available;
    logic              cmd_full;
    logic              pe_issue_valid;
    logic [TASK_W-1:0] pe_issue_data;
    logic              mem_valid;
    logic [PKT_W-1:0]  mem_data;
    logic              stream_begin;
    logic              cntl_done;
    logic              task_complete;
    logic [ITER_W-1:0] replay_iter;
    logic [FV_W-1:0]   num_fv;
    logic [WB_W-1:0]   weights_boundary;

    logic [19:0]       tests [MAX_LINES];
    logic [TASK_W-1:0] pe_expect [$];
    logic [PKT_W-1:0]  mem_expect [$];
    int                value_errors;
    int                other_errors;
    int                begin_count;
    int                done_count;
    logic              done_seen;
    logic              tc_expect;

    tb_clock i_clock (
        .clk (clk)
    );

    gnn_dispatch_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .cmd_push          (cmd_push),
        .cmd_word          (cmd_word),
        .vertex_done       (vertex_done),
        .outbuff_available (outbuff_available),
        .cmd_full          (cmd_full),
        .pe_issue_valid    (pe_issue_valid),
        .pe_issue_data     (pe_issue_data),
        .mem_valid         (mem_valid),
        .mem_data          (mem_data),
        .stream_begin      (stream_begin),
        .cntl_done         (cntl_done),
        .task_complete     (task_complete),
        .replay_iter       (replay_iter),
        .num_fv            (num_fv),
        .weights_boundary  (weights_boundary)
    );

    function automatic logic [15:0] current_value(input logic [3:0] kind);
        case (kind)
            4'h5: return 16'(num_fv);
            4'h6: return 16'(weights_boundary);
            default: return 16'(replay_iter);
        endcase
    endfunction

    function automatic string field_name(input logic [3:0] kind);
        case (kind)
            4'h5: return "num_fv";
            4'h6: return "weights_boundary";
            default: return "replay_iter";
        endcase
    endfunction

    task automatic push_command(input logic [PKT_W-1:0] word);
        int waited;
        waited = 0;
        @(negedge clk);
        while (cmd_full && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (!cmd_full) else begin
            $display("command queue stayed full, word %h was not accepted", word);
            other_errors++;
        end
        cmd_push = 1'b1;
        cmd_word = word;
        @(negedge clk);
        cmd_push = 1'b0;
    endtask

    task automatic set_levels(input logic vd, input logic ob);
        @(negedge clk);
        vertex_done       = vd;
        outbuff_available = ob;
    endtask

    task automatic wait_value(input logic [3:0] kind, input logic [15:0] value);
        int waited;
        waited = 0;
        while (current_value(kind) != value && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (current_value(kind) == value) else begin
            $display("Fail %s expected %h got %h", field_name(kind), value,
                     current_value(kind));
            value_errors++;
        end
    endtask

    task automatic wait_job_done();
        int waited;
        waited = 0;
        while (!done_seen && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (done_seen) else begin
            $display("cntl_done never rose after the last replay");
            other_errors++;
        end
    endtask

    // every expected issue and packet seen
    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((pe_expect.size() + mem_expect.size()) != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert ((pe_expect.size() + mem_expect.size()) == 0) else begin
            $display("still waiting for %0d PE issues and %0d memory packets",
                     pe_expect.size(), mem_expect.size());
            other_errors++;
        end
    endtask

    task automatic check_pe_issue();
        logic [TASK_W-1:0] expected;
        assert (pe_expect.size() > 0) else begin
            $display("PE issue %h arrived with none expected", pe_issue_data);
            other_errors++;
        end
        if (pe_expect.size() > 0) begin
            expected = pe_expect.pop_front();
            assert (pe_issue_data == expected) else begin
                $display("Fail pe_issue_data expected %h got %h", expected, pe_issue_data);
                value_errors++;
            end
        end
    endtask

    task automatic check_mem_packet();
        logic [PKT_W-1:0] expected;
        assert (mem_expect.size() > 0) else begin
            $display("memory packet %h arrived with none expected", mem_data);
            other_errors++;
        end
        if (mem_expect.size() > 0) begin
            expected = mem_expect.pop_front();
            assert (mem_data == expected) else begin
                $display("Fail mem_data expected %h got %h", expected, mem_data);
                value_errors++;
            end
        end
    endtask

    // outputs sampled on the rising edge after inputs settle on the falling one
    always @(posedge clk) begin
        if (reset) begin
            begin_count = 0;
            done_count  = 0;
            done_seen   = 1'b0;
        end else begin
            tc_expect = done_seen && vertex_done && outbuff_available;
            assert (task_complete == tc_expect) else begin
                $display("Fail task_complete expected %h got %h", tc_expect, task_complete);
                value_errors++;
            end
            if (stream_begin) begin
                begin_count++;
            end
            if (cntl_done) begin
                done_count++;
                done_seen = 1'b1;
            end
            if (pe_issue_valid) begin
                check_pe_issue();
            end
            if (mem_valid) begin
                check_mem_packet();
            end
        end
    end

    initial begin
        int         line;
        logic [3:0] kind;
        logic [15:0] value;
        logic       finished;
        cmd_push          = 1'b0;
        cmd_word          = '0;
        vertex_done       = 1'b0;
        outbuff_available = 1'b0;
        reset             = 1'b1;
        value_errors      = 0;
        other_errors      = 0;
        for (int i = 0; i < MAX_LINES; i++) begin
            tests[i] = 20'hF_0000;
        end
        $readmemh("sim/gnn_tests.txt", tests);
        repeat (3) @(negedge clk);
        reset = 1'b0;

        line     = 0;
        finished = 1'b0;
        while (!finished && line < MAX_LINES) begin
            kind  = tests[line][19:16];
            value = tests[line][15:0];
            line++;
            case (kind)
                4'h1: push_command(value);
                4'h2: set_levels(value[1], value[0]);
                4'h3: pe_expect.push_back(value[TASK_W-1:0]);
                4'h4: mem_expect.push_back(value);
                4'h5, 4'h6, 4'h7: wait_value(kind, value);
                4'h8: wait_job_done();
                4'h9: repeat (value) @(negedge clk);
                4'hA: wait_drained();
                4'hB: begin
                    assert (begin_count == int'(value)) else begin
                        $display("Fail stream_begin pulses expected %h got %h",
                                 value, begin_count);
                        value_errors++;
                    end
                end
                4'hF: finished = 1'b1;
                default: begin
                    $display("unknown record kind %h in the tests file", kind);
                    other_errors++;
                end
            endcase
        end

        // exactly one job end
        assert (done_count == 1) else begin
            $display("Fail cntl_done pulses expected %h got %h", 1, done_count);
            value_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: flist.f
src/gnn_cfg_pkg.sv
src/gnn_pkt_pkg.sv
src/dp_status_if.sv
src/pkt_queue.sv
src/dispatch_decoder.sv
src/exec_backend.sv
src/gnn_dispatch_top.sv
sim/tb_clock.sv
sim/gnn_dispatch_assert.sv
sim/gnn_dispatch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dispatch testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module gnn_dispatch_tb -o gnn_dispatch_sim

./obj_dir/gnn_dispatch_sim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi

// File: sim/gnn_tests.txt
// each word is a kind nibble followed by a 16-bit value
// kinds 1 cmd, 2 vertex_done/outbuff levels, 3 pe payload, 4 mem packet, 5 num_fv,
// 6 weights, 7 replay_iter, 8 cntl_done, 9 idle cycles, A drain, B stream_begin count, F end
// pass 0, mask bit 0 set
1_0403
3_0403
1_0C12
3_0C12
1_3C21
3_3C21
// mask bit 0 clear goes to memory
1_0802
4_0802
1_1405
3_1405
A_0000
1_8005
5_0005
1_C009
6_0009
// pass 1
1_4001
4_4001
7_0001
1_0807
3_0807
1_0406
4_0406
1_3C2A
3_3C2A
1_8003
5_0003
// pass 2
1_4002
4_4002
7_0002
1_1011
3_1011
1_2012
4_2012
1_C004
6_0004
// pass 3
1_4003
4_4003
7_0003
1_2013
3_2013
1_0C03
4_0C03
// last replay ends the job
1_4000
8_0000
2_0002
9_0003
2_0003
9_0003
2_0001
9_0002
2_0003
9_0002
2_0000
// stays queued, never decoded
1_3C3F
9_0010
A_0000
B_0002
F_0000
